//--- Bender.yml
package:
  name: vector_lane

export_include_dirs:
  - .

sources:
  - vlane_pkg.sv
  - alu_unit.sv
  - mul_unit.sv
  - div_unit.sv
  - vector_lane.sv
  - target: test
    files:
      - lane_checker.sv
      - tb_vector_lane.sv

//--- alu_unit.sv
`timescale 1ns/1ns
`default_nettype none

`include "vlane_defs.svh"

module alu_unit (
  input  logic                    CLK,
  input  logic                    nRST,
  input  logic                    start,
  input  logic                    stall,
  input  vlane_pkg::lane_op_u     op,
  input  logic [`VLANE_XLEN-1:0]  src_a,
  input  logic [`VLANE_XLEN-1:0]  src_b,
  output logic                    result_valid,
  output logic [`VLANE_XLEN-1:0]  result
);

  localparam int XLEN = `VLANE_XLEN;
  localparam int SHW  = $clog2(XLEN);  // shift amount bits, 5 at 32

  logic [SHW-1:0]  shamt;
  logic [XLEN-1:0] alu_out;
  logic            lt_s;   // signed less-than
  logic            lt_u;   // unsigned less-than

  assign shamt = src_b[SHW-1:0];
  assign lt_s  = $signed(src_a) < $signed(src_b);
  assign lt_u  = src_a < src_b;

  // decode the alu view of the op word
  always_comb begin
    case (op.alu)
      vlane_pkg::OP_ADD:  alu_out = src_a + src_b;
      vlane_pkg::OP_SUB:  alu_out = src_a - src_b;
      vlane_pkg::OP_AND:  alu_out = src_a & src_b;
      vlane_pkg::OP_OR:   alu_out = src_a | src_b;
      vlane_pkg::OP_XOR:  alu_out = src_a ^ src_b;
      vlane_pkg::OP_SLL:  alu_out = src_a << shamt;
      vlane_pkg::OP_SRL:  alu_out = src_a >> shamt;
      vlane_pkg::OP_SRA:  alu_out = $signed(src_a) >>> shamt;  // sign fill
      vlane_pkg::OP_SLT:  alu_out = XLEN'(lt_s);
      vlane_pkg::OP_SLTU: alu_out = XLEN'(lt_u);
      vlane_pkg::OP_MIN:  alu_out = lt_s ? src_a : src_b;
      vlane_pkg::OP_MAX:  alu_out = lt_s ? src_b : src_a;
      vlane_pkg::OP_MINU: alu_out = lt_u ? src_a : src_b;
      vlane_pkg::OP_MAXU: alu_out = lt_u ? src_b : src_a;
      default:            alu_out = '0;  // unused codes
    endcase
  end

  // valid follows start, frozen while the output waits
  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      result_valid <= 1'b0;
    end else if (!stall) begin
      result_valid <= start;  // a held result leaves on this edge
    end
  end

  // result word, only loaded on issue
  always_ff @(posedge CLK) begin
    if (start && !stall) begin
      result <= alu_out;
    end
  end

  // lane must never issue into a stalled alu
  a_no_start_in_stall: assert property (
    @(posedge CLK) disable iff (!nRST) start |-> !stall
  ) else $error("alu start while stalled");

endmodule

`default_nettype wire

//--- build.f
+incdir+.
vlane_pkg.sv
alu_unit.sv
mul_unit.sv
div_unit.sv
vector_lane.sv
lane_checker.sv
tb_vector_lane.sv

//--- div_unit.sv
`timescale 1ns/1ns
`default_nettype none

`include "vlane_defs.svh"

module div_unit (
  input  logic                    CLK,
  input  logic                    nRST,
  input  logic                    start,
  input  logic                    stall,
  input  vlane_pkg::lane_op_u     op,
  input  logic [`VLANE_XLEN-1:0]  src_a,
  input  logic [`VLANE_XLEN-1:0]  src_b,
  output logic                    result_valid,
  output logic [`VLANE_XLEN-1:0]  result,
  output logic                    busy
);

  localparam int XLEN  = `VLANE_XLEN;
  localparam int STEPS = `VLANE_DIV_STEPS;
  localparam int CW    = $clog2(STEPS);

  logic            running;   // steps in progress
  logic [CW-1:0]   step_cnt;
  logic            last_step;

  logic [XLEN-1:0] rem_q;     // partial remainder
  logic [XLEN-1:0] quo_q;     // dividend shifts out, quotient shifts in
  logic [XLEN-1:0] dvsr_q;    // divisor magnitude
  logic            neg_q;     // negate quotient at the end
  logic            neg_r;     // negate remainder at the end
  logic            want_rem;

  logic            sgn;
  logic [XLEN-1:0] mag_a;
  logic [XLEN-1:0] mag_b;
  logic [XLEN:0]   shifted;
  logic [XLEN:0]   diff;
  logic [XLEN-1:0] rem_n;
  logic [XLEN-1:0] quo_n;
  logic [XLEN-1:0] q_fix;
  logic [XLEN-1:0] r_fix;

  assign sgn   = op.md.a_signed;  // b_signed must agree
  assign mag_a = (sgn && src_a[XLEN-1]) ? -src_a : src_a;
  assign mag_b = (sgn && src_b[XLEN-1]) ? -src_b : src_b;

  // one restoring step
  assign shifted = {rem_q, quo_q[XLEN-1]};
  assign diff    = shifted - {1'b0, dvsr_q};
  assign rem_n   = diff[XLEN] ? shifted[XLEN-1:0] : diff[XLEN-1:0];  // borrow restores
  assign quo_n   = {quo_q[XLEN-2:0], ~diff[XLEN]};

  // sign fix on the final step output
  assign q_fix = neg_q ? -quo_n : quo_n;
  assign r_fix = neg_r ? -rem_n : rem_n;

  assign last_step = running && (step_cnt == CW'(STEPS - 1));
  assign busy      = running | result_valid;  // idle only once the result is gone

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      running      <= 1'b0;
      step_cnt     <= '0;
      result_valid <= 1'b0;
    end else if (!stall) begin
      if (start) begin
        running  <= 1'b1;
        step_cnt <= '0;
      end else if (running) begin
        step_cnt <= step_cnt + 1'b1;
        if (last_step) begin
          running <= 1'b0;
        end
      end
      result_valid <= last_step;  // clears when taken, stall keeps it
    end
  end

  always_ff @(posedge CLK) begin
    if (!stall) begin
      if (start) begin
        rem_q    <= '0;
        quo_q    <= mag_a;
        dvsr_q   <= mag_b;
        // div by zero keeps the all-ones quotient unsigned
        // min / -1 wraps back to min by itself
        neg_q    <= sgn & (src_a[XLEN-1] ^ src_b[XLEN-1]) & (src_b != '0);
        neg_r    <= sgn & src_a[XLEN-1];  // remainder takes dividend sign
        want_rem <= op.md.rem;
      end else if (running) begin
        rem_q <= rem_n;
        quo_q <= quo_n;
        if (last_step) begin
          result <= want_rem ? r_fix : q_fix;  // final step straight into result
        end
      end
    end
  end

  // one divide at a time, lane gates start on busy
  a_no_start_busy: assert property (
    @(posedge CLK) disable iff (!nRST) start |-> !busy
  ) else $error("div start while busy");

  // mixed signedness has no meaning for divide
  a_sign_agree: assert property (
    @(posedge CLK) disable iff (!nRST) start |-> (op.md.a_signed == op.md.b_signed)
  ) else $error("div signedness flags differ");

endmodule

`default_nettype wire

//--- lane_checker.sv
`timescale 1ns/1ns
`default_nettype none

`include "vlane_defs.svh"

module lane_checker (
  input  logic                    CLK,
  input  logic                    nRST,
  input  logic                    in_valid,
  input  logic                    in_ready,
  input  vlane_pkg::fu_type_t     fu_type,
  input  vlane_pkg::lane_op_u     op,
  input  logic [`VLANE_XLEN-1:0]  src_a,
  input  logic [`VLANE_XLEN-1:0]  src_b,
  input  logic                    out_valid,
  input  logic                    out_ready,
  input  logic [`VLANE_XLEN-1:0]  lane_result,
  output int                      errors,
  output int                      checks,
  output int                      pending
);

  localparam int XLEN = `VLANE_XLEN;

  logic [XLEN-1:0] expq[$];  // expected results in issue order
  logic [XLEN-1:0] exp_v;
  logic [XLEN-1:0] held;     // result seen while out_ready was low
  logic            hold;

  function automatic logic [XLEN-1:0] model_alu(input vlane_pkg::alu_op_t code,
                                                input logic [XLEN-1:0] a,
                                                input logic [XLEN-1:0] b);
    logic [4:0] sh;
    sh = b[4:0];  // low 5 bits only
    case (code)
      vlane_pkg::OP_ADD:  return a + b;
      vlane_pkg::OP_SUB:  return a - b;
      vlane_pkg::OP_AND:  return a & b;
      vlane_pkg::OP_OR:   return a | b;
      vlane_pkg::OP_XOR:  return a ^ b;
      vlane_pkg::OP_SLL:  return a << sh;
      vlane_pkg::OP_SRL:  return a >> sh;
      vlane_pkg::OP_SRA:  return (a >> sh) | (a[XLEN-1] ? ~({XLEN{1'b1}} >> sh) : '0);
      vlane_pkg::OP_SLT:  return ($signed(a) < $signed(b)) ? 1 : 0;
      vlane_pkg::OP_SLTU: return (a < b) ? 1 : 0;
      vlane_pkg::OP_MIN:  return ($signed(a) <= $signed(b)) ? a : b;
      vlane_pkg::OP_MAX:  return ($signed(a) >= $signed(b)) ? a : b;
      vlane_pkg::OP_MINU: return (a <= b) ? a : b;
      vlane_pkg::OP_MAXU: return (a >= b) ? a : b;
      default:            return '0;  // codes 14, 15
    endcase
  endfunction

  // 64-bit product of the extended operands, low 64 bits hold for every sign mix
  function automatic logic [XLEN-1:0] model_mul(input vlane_pkg::muldiv_op_t f,
                                                input logic [XLEN-1:0] a,
                                                input logic [XLEN-1:0] b);
    logic [2*XLEN-1:0] ax;
    logic [2*XLEN-1:0] bx;
    logic [2*XLEN-1:0] p;
    ax = f.a_signed ? {{XLEN{a[XLEN-1]}}, a} : {{XLEN{1'b0}}, a};
    bx = f.b_signed ? {{XLEN{b[XLEN-1]}}, b} : {{XLEN{1'b0}}, b};
    p  = ax * bx;
    return f.upper ? p[2*XLEN-1:XLEN] : p[XLEN-1:0];
  endfunction

  // risc-v div/rem, no traps
  function automatic logic [XLEN-1:0] model_div(input vlane_pkg::muldiv_op_t f,
                                                input logic [XLEN-1:0] a,
                                                input logic [XLEN-1:0] b);
    logic [XLEN-1:0] q;
    logic [XLEN-1:0] r;
    logic [XLEN-1:0] min_v;
    min_v = {1'b1, {(XLEN-1){1'b0}}};
    if (b == '0) begin
      q = '1;  // all ones, remainder is the dividend
      r = a;
    end else if (f.a_signed && a == min_v && b == '1) begin
      q = min_v;  // overflow case
      r = '0;
    end else if (f.a_signed) begin
      q = $signed(a) / $signed(b);  // truncates toward zero
      r = $signed(a) % $signed(b);
    end else begin
      q = a / b;
      r = a % b;
    end
    return f.rem ? r : q;
  endfunction

  initial begin
    errors  = 0;
    checks  = 0;
    pending = 0;
    hold    = 1'b0;
  end

  // sample mid-cycle, the values here are what the next rising edge sees
  always @(negedge CLK) begin
    if (nRST) begin
      if (hold) begin
        if (!out_valid) begin
          $display("ERROR: out_valid dropped while its result waited for out_ready");
          errors++;
        end else if (lane_result !== held) begin
          $display("FAILED lane_result: %h changed to %h while stalled", held, lane_result);
          errors++;
        end
      end
      if (out_valid && out_ready) begin  // pop before push, no same-cycle result
        if (expq.size() == 0) begin
          $display("ERROR: result %h left the lane with no op outstanding", lane_result);
          errors++;
        end else begin
          exp_v = expq.pop_front();
          checks++;
          if (lane_result !== exp_v) begin
            $display("FAILED lane_result: got %h expected %h", lane_result, exp_v);
            errors++;
          end
        end
      end
      if (in_valid && in_ready) begin
        case (fu_type)
          vlane_pkg::FU_ALU: expq.push_back(model_alu(op.alu, src_a, src_b));
          vlane_pkg::FU_MUL: expq.push_back(model_mul(op.md, src_a, src_b));
          default:           expq.push_back(model_div(op.md, src_a, src_b));
        endcase
      end
      hold = out_valid && !out_ready;
      held = lane_result;
    end else begin
      hold = 1'b0;
    end
    pending = expq.size();
  end

endmodule

`default_nettype wire

//--- mul_unit.sv
`timescale 1ns/1ns
`default_nettype none

`include "vlane_defs.svh"

module mul_unit (
  input  logic                    CLK,
  input  logic                    nRST,
  input  logic                    start,
  input  logic                    stall,
  input  vlane_pkg::lane_op_u     op,
  input  logic [`VLANE_XLEN-1:0]  src_a,
  input  logic [`VLANE_XLEN-1:0]  src_b,
  output logic                    result_valid,
  output logic [`VLANE_XLEN-1:0]  result
);

  localparam int XLEN   = `VLANE_XLEN;
  localparam int STAGES = `VLANE_MUL_STAGES;

  // stage 1 operands extended by one bit
  logic [XLEN:0]      s1_a;
  logic [XLEN:0]      s1_b;
  logic               s1_up;

  // stage 2 full product of the 33-bit operands
  logic [2*XLEN+1:0]  s2_prod;
  logic               s2_up;

  // one valid bit per stage
  logic [STAGES-1:0]  vld;

  assign result_valid = vld[STAGES-1];  // last stage is the output

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      vld <= '0;
    end else if (!stall) begin
      vld <= {vld[STAGES-2:0], start};  // shift in the new op
    end
  end

  // payload stages freeze together with the valid bits
  always_ff @(posedge CLK) begin
    if (!stall) begin
      // sign or zero extend per flag
      s1_a  <= {op.md.a_signed & src_a[XLEN-1], src_a};
      s1_b  <= {op.md.b_signed & src_b[XLEN-1], src_b};
      s1_up <= op.md.upper;

      s2_prod <= $signed(s1_a) * $signed(s1_b);  // 33x33 signed covers su/uu too
      s2_up   <= s1_up;

      // mulh* takes the high word
      result <= s2_up ? s2_prod[2*XLEN-1:XLEN] : s2_prod[XLEN-1:0];
    end
  end

  // new valid bits enter only while the pipe moves
  a_hold_in_stall: assert property (
    @(posedge CLK) disable iff (!nRST) start |-> !stall
  ) else $error("mul start while stalled");

endmodule

`default_nettype wire

//--- tb_vector_lane.sv
`timescale 1ns/1ns
`default_nettype none

`include "vlane_defs.svh"

module tb_vector_lane;

  localparam int XLEN  = `VLANE_XLEN;
  localparam int N_ALU = 80;
  localparam int N_MUL = 60;
  localparam int N_DIV = 24;  // directed corner cases included
  localparam int N_MIX = 60;
  localparam int N_BP  = 40;
  localparam int N_OPS = 1 + N_ALU + N_MUL + N_DIV + N_MIX + N_BP;
  localparam int TIMEOUT_NS = N_OPS * 40 * 8 + 4000;
  localparam logic [XLEN-1:0] MIN_V = {1'b1, {(XLEN-1){1'b0}}};

  logic CLK, nRST, in_valid, in_ready, out_valid, out_ready, busy;
  vlane_pkg::fu_type_t fu_type;
  vlane_pkg::lane_op_u op;
  logic [XLEN-1:0] src_a, src_b, lane_result;

  integer seed;
  integer ready_seed;
  int ready_mode;  // 0 always ready, 1 about 75 %, 2 long low spans
  int span;
  int waits;       // cycles an op waited for in_ready
  int tb_errors, chk_errors, checks, pending, mark;

  always #4 CLK = ~CLK;

  vector_lane u_vector_lane (
    .CLK(CLK), .nRST(nRST),
    .in_valid(in_valid), .in_ready(in_ready), .fu_type(fu_type), .op(op),
    .src_a(src_a), .src_b(src_b),
    .out_valid(out_valid), .out_ready(out_ready), .lane_result(lane_result), .busy(busy)
  );

  lane_checker u_check (
    .CLK(CLK), .nRST(nRST),
    .in_valid(in_valid), .in_ready(in_ready), .fu_type(fu_type), .op(op),
    .src_a(src_a), .src_b(src_b),
    .out_valid(out_valid), .out_ready(out_ready), .lane_result(lane_result),
    .errors(chk_errors), .checks(checks), .pending(pending)
  );

  // output back-pressure pattern
  always @(posedge CLK) begin
    #1;
    case (ready_mode)
      0: out_ready = 1'b1;
      1: out_ready = ($unsigned($random(ready_seed)) % 4) != 0;
      default: begin
        if (span == 0) begin
          out_ready = ~out_ready;
          span = out_ready ? 1 + $unsigned($random(ready_seed)) % 4
                           : 8 + $unsigned($random(ready_seed)) % 16;
        end else begin
          span = span - 1;
        end
      end
    endcase
  end

  function automatic logic [XLEN-1:0] rand_operand();
    case ($unsigned($random(seed)) % 8)
      0: return '0;
      1: return 1;
      2: return '1;
      3: return MIN_V;
      4: return ~MIN_V;
      5: return $unsigned($random(seed)) % 40;  // small, shift amounts too
      default: return $random(seed);
    endcase
  endfunction

  // called just after a rising edge, returns just after the accept edge
  task send_op(input vlane_pkg::fu_type_t fu, input logic [3:0] code,
               input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
    fu_type  = fu;
    op       = code;
    src_a    = a;
    src_b    = b;
    in_valid = 1'b1;
    @(negedge CLK);
    while (!in_ready) begin
      waits++;
      @(negedge CLK);
    end
    @(posedge CLK);
    #1;
  endtask

  // kind 0 alu, 1 mul, 2 div, 3 any unit
  task rand_op(input int kind);
    logic [1:0] k;
    logic [3:0] code;
    logic       s;
    k = (kind == 3) ? $unsigned($random(seed)) % 3 : kind;
    case (k)
      2'd0: code = $unsigned($random(seed)) % 16;
      2'd1: code = $random(seed);  // every flag mix
      default: begin
        s    = $random(seed);
        code = {s, s, 2'($random(seed))};  // signedness flags agree
      end
    endcase
    send_op(vlane_pkg::fu_type_t'(k), code, rand_operand(), rand_operand());
  endtask

  task finish_test(input string name, input int n_ops);
    int cycles;
    in_valid = 1'b0;
    cycles   = 0;
    @(negedge CLK);
    while ((busy || pending != 0) && cycles < 600) begin
      cycles++;
      @(negedge CLK);
    end
    if (busy || pending != 0) begin
      $display("ERROR: lane did not drain after %s, %0d results missing", name, pending);
      tb_errors++;
    end
    $display("test %-18s %4d ops  %0d errors", name, n_ops, tb_errors + chk_errors - mark);
    mark = tb_errors + chk_errors;
    @(posedge CLK);
    #1;
  endtask

  initial begin
    #(TIMEOUT_NS);
    $display("ERROR: run timed out after %0d ns, results stopped leaving the lane", TIMEOUT_NS);
    $display("*** TEST FAILED ***");
    $finish;
  end

  initial begin
    seed       = 32'h4ee4dc3b;
    ready_seed = seed + 1;
    CLK = 1'b0;
    nRST = 1'b0;
    in_valid = 1'b0;
    fu_type = vlane_pkg::FU_ALU;
    op = '0;
    src_a = '0;
    src_b = '0;
    out_ready = 1'b1;
    ready_mode = 0;
    span = 0;
    waits = 0;
    tb_errors = 0;
    mark = 0;
    repeat (3) @(posedge CLK);
    #1 nRST = 1'b1;

    // idle state, then one alu op with a fixed latency
    @(negedge CLK);
    if (out_valid || busy || !in_ready) begin
      $display("ERROR: lane not idle after reset, out_valid %b busy %b in_ready %b",
               out_valid, busy, in_ready);
      tb_errors++;
    end
    @(posedge CLK);
    #1;
    send_op(vlane_pkg::FU_ALU, vlane_pkg::OP_ADD, 32'h0000_1234, 32'h0000_0fff);
    in_valid = 1'b0;
    @(negedge CLK);
    if (!out_valid) begin
      $display("ERROR: alu result not valid one cycle after its accept");
      tb_errors++;
    end
    @(negedge CLK);
    if (out_valid) begin
      $display("ERROR: alu result stayed valid after it was taken");
      tb_errors++;
    end
    finish_test("reset_alu_latency", 1);

    ready_mode = 1;
    repeat (N_ALU) rand_op(0);
    finish_test("alu_random", N_ALU);

    // first half unthrottled, every cycle should accept
    ready_mode = 0;
    waits = 0;
    repeat (N_MUL / 2) rand_op(1);
    if (waits != 0) begin
      $display("ERROR: multiplier waited %0d cycles for in_ready with out_ready high", waits);
      tb_errors++;
    end
    ready_mode = 1;
    repeat (N_MUL - N_MUL / 2) rand_op(1);
    finish_test("mul_random", N_MUL);

    send_op(vlane_pkg::FU_DIV, 4'b1100, MIN_V, 32'hffff_ffff);  // min / -1
    send_op(vlane_pkg::FU_DIV, 4'b1101, MIN_V, 32'hffff_ffff);
    send_op(vlane_pkg::FU_DIV, 4'b1100, 32'h8765_4321, '0);     // by zero
    send_op(vlane_pkg::FU_DIV, 4'b0001, 32'h8765_4321, '0);
    repeat (N_DIV - 4) rand_op(2);
    finish_test("div_random", N_DIV);

    repeat (N_MIX) rand_op(3);
    finish_test("mixed_units", N_MIX);

    ready_mode = 2;
    repeat (N_BP) rand_op(3);
    finish_test("back_pressure", N_BP);

    $display("%0d results checked, %0d errors", checks, tb_errors + chk_errors);
    if (tb_errors + chk_errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- vector_lane.sv
`timescale 1ns/1ns
`default_nettype none

`include "vlane_defs.svh"

module vector_lane (
  input  logic                    CLK,
  input  logic                    nRST,
  input  logic                    in_valid,
  output logic                    in_ready,
  input  vlane_pkg::fu_type_t     fu_type,
  input  vlane_pkg::lane_op_u     op,
  input  logic [`VLANE_XLEN-1:0]  src_a,
  input  logic [`VLANE_XLEN-1:0]  src_b,
  output logic                    out_valid,
  input  logic                    out_ready,
  output logic [`VLANE_XLEN-1:0]  lane_result,
  output logic                    busy
);

  localparam int XLEN = `VLANE_XLEN;
  localparam logic [1:0] MAX_INFLIGHT = 2'(`VLANE_MUL_STAGES);  // mul pipe fills the count

  logic au, mlu, dvs;            // one-hot unit selects
  logic type_ok, mul_room, stall;
  logic alu_start, mul_start, div_start;
  logic dv, dv_q, done_q;        // divide edge start
  logic in_fire, out_fire;
  logic alu_v, mul_v, div_v, div_busy;
  logic [XLEN-1:0] alu_res, mul_res, div_res;

  vlane_pkg::fu_type_t inflight_type;  // unit of the ops still inside
  logic [1:0]          inflight_cnt;

  assign au  = fu_type == vlane_pkg::FU_ALU;
  assign mlu = fu_type == vlane_pkg::FU_MUL;
  assign dvs = fu_type == vlane_pkg::FU_DIV;

  assign out_valid = alu_v | mul_v | div_v;
  assign stall     = out_valid & ~out_ready;  // broadcast, all units hold
  assign out_fire  = out_valid & out_ready;
  assign busy      = inflight_cnt != 2'd0;

  // results stay in order if only one unit type is in flight
  assign type_ok  = (inflight_cnt == 2'd0) || (inflight_type == fu_type);
  assign mul_room = (inflight_cnt < MAX_INFLIGHT) | out_fire;

  // illegal type is taken and dropped, so the lane never hangs on it
  assign in_ready = (au  & ~stall & type_ok)
                  | (mlu & ~stall & type_ok & mul_room)
                  | (dvs & ~div_busy & type_ok)
                  | ~(au | mlu | dvs);

  assign alu_start = in_valid & in_ready & au;
  assign mul_start = in_valid & in_ready & mlu;
  assign dv        = in_valid & in_ready & dvs;  // gated divide select

  // rising edge of the divide select, or a finished divide with another behind it
  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      dv_q   <= 1'b0;
      done_q <= 1'b0;
    end else begin
      dv_q   <= dv;
      done_q <= div_v & out_ready;  // divide result left
    end
  end
  assign div_start = (dv & ~dv_q) | (done_q & dv);

  assign in_fire = alu_start | mul_start | div_start;

  // in-flight tracking
  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      inflight_type <= vlane_pkg::FU_ALU;
      inflight_cnt  <= 2'd0;
    end else begin
      if (in_fire) begin
        inflight_type <= fu_type;
      end
      case ({in_fire, out_fire})
        2'b10:   inflight_cnt <= inflight_cnt + 2'd1;
        2'b01:   inflight_cnt <= inflight_cnt - 2'd1;
        default: inflight_cnt <= inflight_cnt;  // none or one in, one out
      endcase
    end
  end

  alu_unit u_alu (
    .CLK(CLK), .nRST(nRST),
    .start(alu_start), .stall(stall), .op(op),
    .src_a(src_a), .src_b(src_b),
    .result_valid(alu_v), .result(alu_res)
  );

  mul_unit u_mul (
    .CLK(CLK), .nRST(nRST),
    .start(mul_start), .stall(stall), .op(op),
    .src_a(src_a), .src_b(src_b),
    .result_valid(mul_v), .result(mul_res)
  );

  div_unit u_div (
    .CLK(CLK), .nRST(nRST),
    .start(div_start), .stall(stall), .op(op),
    .src_a(src_a), .src_b(src_b),
    .result_valid(div_v), .result(div_res), .busy(div_busy)
  );

  // final select by the unit holding a result
  assign lane_result = alu_v ? alu_res :
                       mul_v ? mul_res :
                       div_v ? div_res :
                       '0;

  // issue rule keeps units from finishing together
  a_one_result: assert property (
    @(posedge CLK) disable iff (!nRST) $onehot0({alu_v, mul_v, div_v})
  ) else $error("more than one unit result valid");

  // edge start must never miss an accepted divide
  a_div_accept: assert property (
    @(posedge CLK) disable iff (!nRST) dv |-> div_start
  ) else $error("divide accepted without a start");

endmodule

`default_nettype wire

//--- vlane_defs.svh
`ifndef VLANE_DEFS_SVH
`define VLANE_DEFS_SVH

// lane element width, one 32-bit element per op
`define VLANE_XLEN 32

// multiplier pipe depth
// extend, multiply, select word
`define VLANE_MUL_STAGES 3

// restoring divider, one quotient bit per step
`define VLANE_DIV_STEPS `VLANE_XLEN

`endif

//--- vlane_pkg.sv
`default_nettype none

package vlane_pkg;

  // unit type from issue, 2'b11 is illegal
  typedef enum logic [1:0] {
    FU_ALU = 2'd0,
    FU_MUL = 2'd1,
    FU_DIV = 2'd2
  } fu_type_t;

  // alu view of the op word, codes 14 and 15 give zero
  typedef enum logic [3:0] {
    OP_ADD  = 4'd0,
    OP_SUB  = 4'd1,
    OP_AND  = 4'd2,
    OP_OR   = 4'd3,
    OP_XOR  = 4'd4,
    OP_SLL  = 4'd5,
    OP_SRL  = 4'd6,
    OP_SRA  = 4'd7,
    OP_SLT  = 4'd8,
    OP_SLTU = 4'd9,
    OP_MIN  = 4'd10,
    OP_MAX  = 4'd11,
    OP_MINU = 4'd12,
    OP_MAXU = 4'd13
  } alu_op_t;

  // mul/div view, upper is unused by div and rem is unused by mul
  typedef struct packed {
    logic a_signed;  // src_a treated as signed
    logic b_signed;  // src_b signed, must match a_signed for div
    logic upper;     // mul: high word of the product
    logic rem;       // div: remainder instead of quotient
  } muldiv_op_t;

  // one op word, read by the unit it goes to
  typedef union packed {
    alu_op_t    alu;
    muldiv_op_t md;
  } lane_op_u;

endpackage

`default_nettype wire
